// ==== verif/btb_stim.txt ====
# Kinds: U pc target (hex), L pc expected_next_pc expected_hit (hex), S preds fetch_credits (dec)
# T name starts a test, E ends it, W/R withhold/resume consumer credits, X resets the DUT
T cold_miss
L 00001000 00001004 0
L 00002000 00002004 0
L 00000000 00000004 0
L 0000fffc 00010000 0
E
T update_hit
U 00001000 00008000
L 00001000 00008000 1
L 00001004 00001008 0
L 00002000 00002004 0
E
T retarget_evict
U 00001000 00009000
L 00001000 00009000 1
U 00003000 0000a000
U 00003100 0000a100
U 00003200 0000a200
U 00003300 0000a300
U 00003400 0000a400
U 00003500 0000a500
U 00003600 0000a600
L 00001000 00009000 1
U 00003700 0000a700
L 00001000 00001004 0
L 00003000 0000a000 1
E
T round_robin
X
U 00004000 0000b000
U 00004100 0000b100
U 00004200 0000b200
U 00004300 0000b300
U 00004400 0000b400
U 00004500 0000b500
U 00004600 0000b600
U 00004700 0000b700
U 00004800 0000b800
L 00004000 00004004 0
L 00004100 0000b100 1
L 00004200 0000b200 1
L 00004300 0000b300 1
L 00004400 0000b400 1
L 00004500 0000b500 1
L 00004600 0000b600 1
L 00004700 0000b700 1
L 00004800 0000b800 1
E
T back_pressure
W
L 00004100 0000b100 1
L 00005000 00005004 0
L 00004300 0000b300 1
L 00005100 00005104 0
L 00004500 0000b500 1
L 00005200 00005204 0
S 2 0
R
E
T reset_clears
L 00004200 0000b200 1
X
L 00004200 00004204 0
L 00004800 00004804 0
E

// ==== flist.f ====
common/btb_pkg.sv
logic/pc_request_queue.sv
btb/btb_table.sv
logic/prediction_out.sv
logic/btb_top.sv
verif/btb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= btb_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench prints its pass line
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/btb_tb.sv ====
module btb_tb;

  localparam int clk_period = 100;
  localparam int reset_cycles = 10;
  localparam int settle_cycles = 10;
  localparam int watchdog_cycles_per_line = 200;

  logic                           clk;
  logic                           reset;
  logic                           req_valid;
  logic [btb_pkg::addr_width-1:0] req_pc;
  logic                           req_credit;
  logic                           upd_valid;
  logic [btb_pkg::addr_width-1:0] upd_pc;
  logic [btb_pkg::addr_width-1:0] upd_target;
  logic                           pred_credit;
  logic                           pred_valid;
  logic [btb_pkg::addr_width-1:0] pred_pc;
  logic [btb_pkg::addr_width-1:0] pred_next_pc;
  logic                           pred_hit;

  // Fetch side and consumer side bookkeeping
  int fetch_credits;
  int owed_credits;
  bit withhold;

  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  int preds_in_test;
  int line_count;
  bit in_test;
  string test_name;

  // Expected predictions in request order
  logic [btb_pkg::addr_width-1:0] exp_pc [$];
  logic [btb_pkg::addr_width-1:0] exp_next [$];
  logic                           exp_hit [$];

  btb_top uut (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_pc       (req_pc),
    .req_credit   (req_credit),
    .upd_valid    (upd_valid),
    .upd_pc       (upd_pc),
    .upd_target   (upd_target),
    .pred_credit  (pred_credit),
    .pred_valid   (pred_valid),
    .pred_pc      (pred_pc),
    .pred_next_pc (pred_next_pc),
    .pred_hit     (pred_hit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Every falling edge of the run passes through this task
  task automatic tick();
    logic [31:0] e_pc;
    logic [31:0] e_next;
    logic        e_hit;
    @(negedge clk);
    req_valid = 1'b0;
    upd_valid = 1'b0;
    // A credit goes back the cycle after its prediction was seen
    if (!withhold && owed_credits > 0) begin
      pred_credit = 1'b1;
      owed_credits--;
    end else begin
      pred_credit = 1'b0;
    end
    if (req_credit) begin
      fetch_credits++;
    end
    if (pred_valid) begin
      preds_in_test++;
      owed_credits++;
      if (exp_pc.size() == 0) begin
        errors++;
        test_errors++;
        $display("Unexpected prediction for pc %h at time %0t, no lookup was waiting",
                 pred_pc, $time);
      end else begin
        e_pc = exp_pc.pop_front();
        e_next = exp_next.pop_front();
        e_hit = exp_hit.pop_front();
        check_value(pred_pc, e_pc, "pred_pc");
        check_value(pred_next_pc, e_next, $sformatf("pred_next_pc for pc %h", e_pc));
        check_value({31'b0, pred_hit}, {31'b0, e_hit},
                    $sformatf("pred_hit for pc %h", e_pc));
      end
    end
  endtask

  task automatic drain();
    while (exp_pc.size() != 0) begin
      tick();
    end
  endtask

  task automatic send_lookup(input logic [31:0] pc, input logic [31:0] next_pc,
                             input logic hit);
    while (fetch_credits == 0) begin
      tick();
    end
    exp_pc.push_back(pc);
    exp_next.push_back(next_pc);
    exp_hit.push_back(hit);
    req_valid = 1'b1;
    req_pc = pc;
    fetch_credits--;
    tick();
  endtask

  task automatic send_update(input logic [31:0] pc, input logic [31:0] target);
    drain();
    upd_valid = 1'b1;
    upd_pc = pc;
    upd_target = target;
    tick();
  endtask

  task automatic apply_reset();
    drain();
    owed_credits = 0;
    pred_credit = 1'b0;
    reset = 1'b1;
    repeat (reset_cycles) tick();
    reset = 1'b0;
    fetch_credits = btb_pkg::req_depth;
  endtask

  task automatic settle_and_count(input int exp_preds, input int exp_fetch);
    repeat (settle_cycles) tick();
    check_value(32'(preds_in_test), 32'(exp_preds), "predictions so far in test");
    check_value(32'(fetch_credits), 32'(exp_fetch), "fetch credits held");
  endtask

  task automatic finish_test();
    drain();
    while (!withhold && owed_credits != 0) begin
      tick();
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", test_name, test_errors);
    end
    in_test = 1'b0;
  endtask

  function automatic string chomp(input string s);
    string r;
    r = s;
    while (r.len() > 0 && (r.getc(r.len() - 1) == "\n" || r.getc(r.len() - 1) == "\r" ||
           r.getc(r.len() - 1) == " ")) begin
      r = r.substr(0, r.len() - 2);
    end
    return r;
  endfunction

  task automatic malformed(input string line);
    errors++;
    $display("Malformed stimulus line, could not parse: %s", line);
  endtask

  task automatic run_stimulus(input int fd);
    string line;
    string body;
    byte kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int n1;
    int n2;
    while ($fgets(line, fd) != 0) begin
      line = chomp(line);
      if (line.len() > 0) begin
        kind = line.getc(0);
        if (line.len() > 2) begin
          body = line.substr(2, line.len() - 1);
        end else begin
          body = "";
        end
        case (kind)
          "#": begin
          end
          "T": begin
            if (in_test) begin
              finish_test();
            end
            test_name = body;
            test_errors = 0;
            preds_in_test = 0;
            in_test = 1'b1;
          end
          "E": finish_test();
          "U": begin
            if ($sscanf(body, "%h %h", a, b) != 2) malformed(line);
            else send_update(a, b);
          end
          "L": begin
            if ($sscanf(body, "%h %h %h", a, b, c) != 3) malformed(line);
            else send_lookup(a, b, c[0]);
          end
          "S": begin
            if ($sscanf(body, "%d %d", n1, n2) != 2) malformed(line);
            else settle_and_count(n1, n2);
          end
          "W": withhold = 1'b1;
          "R": withhold = 1'b0;
          "X": apply_reset();
          default: malformed(line);
        endcase
      end
    end
    if (in_test) begin
      finish_test();
    end
  endtask

  initial begin
    int fd;
    string line;
    reset = 1'b1;
    req_valid = 1'b0;
    req_pc = '0;
    upd_valid = 1'b0;
    upd_pc = '0;
    upd_target = '0;
    pred_credit = 1'b0;
    fetch_credits = 0;
    owed_credits = 0;
    withhold = 1'b0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    preds_in_test = 0;
    in_test = 1'b0;
    line_count = 0;

    fd = $fopen("verif/btb_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file verif/btb_stim.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_count++;
      end
      $fclose(fd);
      fd = $fopen("verif/btb_stim.txt", "r");
      apply_reset();
      run_stimulus(fd);
      $fclose(fd);
    end

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Run length scales with the number of stimulus lines
  initial begin
    wait (line_count > 0);
    repeat (line_count * watchdog_cycles_per_line) @(posedge clk);
    $display("Timed out after %0d cycles, the stimulus did not finish",
             line_count * watchdog_cycles_per_line);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== logic/btb_top.sv ====
module btb_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           req_valid,
  input  logic [btb_pkg::addr_width-1:0] req_pc,
  output logic                           req_credit,
  input  logic                           upd_valid,
  input  logic [btb_pkg::addr_width-1:0] upd_pc,
  input  logic [btb_pkg::addr_width-1:0] upd_target,
  input  logic                           pred_credit,
  output logic                           pred_valid,
  output logic [btb_pkg::addr_width-1:0] pred_pc,
  output logic [btb_pkg::addr_width-1:0] pred_next_pc,
  output logic                           pred_hit
);

  logic                           q_valid;
  logic [btb_pkg::addr_width-1:0] q_pc;
  logic                           q_pop;
  logic [btb_pkg::addr_width-1:0] read_val;
  logic                           read_hit;

  pc_request_queue u_queue (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_pc     (req_pc),
    .q_pop      (q_pop),
    .q_valid    (q_valid),
    .q_pc       (q_pc),
    .req_credit (req_credit)
  );

  // Head of the queue looks up the table directly
  btb_table u_table (
    .clk        (clk),
    .reset      (reset),
    .upd_valid  (upd_valid),
    .upd_pc     (upd_pc),
    .upd_target (upd_target),
    .read_key   (q_pc),
    .read_val   (read_val),
    .read_hit   (read_hit)
  );

  prediction_out u_pred (
    .clk          (clk),
    .reset        (reset),
    .q_valid      (q_valid),
    .q_pc         (q_pc),
    .read_val     (read_val),
    .read_hit     (read_hit),
    .pred_credit  (pred_credit),
    .q_pop        (q_pop),
    .pred_valid   (pred_valid),
    .pred_pc      (pred_pc),
    .pred_next_pc (pred_next_pc),
    .pred_hit     (pred_hit)
  );

endmodule

// ==== logic/prediction_out.sv ====
module prediction_out (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           q_valid,
  input  logic [btb_pkg::addr_width-1:0] q_pc,
  input  logic [btb_pkg::addr_width-1:0] read_val,
  input  logic                           read_hit,
  input  logic                           pred_credit,
  output logic                           q_pop,
  output logic                           pred_valid,
  output logic [btb_pkg::addr_width-1:0] pred_pc,
  output logic [btb_pkg::addr_width-1:0] pred_next_pc,
  output logic                           pred_hit
);

  logic [btb_pkg::pred_credit_width-1:0] credit_cnt;
  logic [btb_pkg::addr_width-1:0]        next_pc;

  // Send whenever a request waits and the consumer has room
  assign q_pop = q_valid && (credit_cnt != '0);

  assign next_pc = read_hit ? read_val
                            : q_pc + btb_pkg::addr_width'(btb_pkg::inst_step);

  // Downstream credits, a send and a returned credit can coincide
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= btb_pkg::pred_credit_width'(btb_pkg::pred_credits);
    end else begin
      case ({q_pop, pred_credit})
        2'b10: credit_cnt <= credit_cnt - 1'b1;
        2'b01: credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pred_valid <= 1'b0;
    end else begin
      pred_valid <= q_pop;
    end
  end

  // Prediction payload, captured on the pop edge
  always_ff @(posedge clk) begin
    if (q_pop) begin
      pred_pc      <= q_pc;
      pred_next_pc <= next_pc;
      pred_hit     <= read_hit;
    end
  end

endmodule

// ==== btb/btb_table.sv ====
module btb_table (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           upd_valid,
  input  logic [btb_pkg::addr_width-1:0] upd_pc,
  input  logic [btb_pkg::addr_width-1:0] upd_target,
  input  logic [btb_pkg::addr_width-1:0] read_key,
  output logic [btb_pkg::addr_width-1:0] read_val,
  output logic                           read_hit
);

  logic [btb_pkg::addr_width-1:0]      keys [btb_pkg::btb_entries];
  logic [btb_pkg::addr_width-1:0]      vals [btb_pkg::btb_entries];
  logic [btb_pkg::btb_entries-1:0]     valid;
  logic [btb_pkg::btb_index_width-1:0] rr_ptr;
  logic [btb_pkg::btb_index_width-1:0] rr_next;

  logic                                upd_hit;
  logic [btb_pkg::btb_index_width-1:0] upd_idx;
  logic [btb_pkg::btb_index_width-1:0] wr_idx;

  // Lookup, lowest matching valid entry wins
  always_comb begin
    read_hit = 1'b0;
    read_val = '0;
    for (int i = 0; i < btb_pkg::btb_entries; i++) begin
      if (!read_hit && valid[i] && (keys[i] == read_key)) begin
        read_hit = 1'b1;
        read_val = vals[i];
      end
    end
  end

  // Does the update key already live in the table
  always_comb begin
    upd_hit = 1'b0;
    upd_idx = '0;
    for (int i = 0; i < btb_pkg::btb_entries; i++) begin
      if (!upd_hit && valid[i] && (keys[i] == upd_pc)) begin
        upd_hit = 1'b1;
        upd_idx = btb_pkg::btb_index_width'(i);
      end
    end
  end

  assign rr_next = (rr_ptr == btb_pkg::btb_index_width'(btb_pkg::btb_entries - 1)) ?
                   '0 : rr_ptr + 1'b1;

  // Existing entry is retargeted, otherwise allocate at the pointer
  assign wr_idx = upd_hit ? upd_idx : rr_ptr;

  // Key and target storage
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      vals[wr_idx] <= upd_target;
      if (!upd_hit) begin
        keys[wr_idx] <= upd_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid  <= '0;
      rr_ptr <= '0;
    end else if (upd_valid && !upd_hit) begin
      valid[rr_ptr] <= 1'b1;
      rr_ptr        <= rr_next;
    end
  end

endmodule

// ==== logic/pc_request_queue.sv ====
module pc_request_queue (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req_valid,
  input  logic [btb_pkg::addr_width-1:0]    req_pc,
  input  logic                              q_pop,
  output logic                              q_valid,
  output logic [btb_pkg::addr_width-1:0]    q_pc,
  output logic                              req_credit
);

  logic [btb_pkg::addr_width-1:0]      mem [btb_pkg::req_depth];
  logic [btb_pkg::req_ptr_width-1:0]   wr_ptr;
  logic [btb_pkg::req_ptr_width-1:0]   rd_ptr;
  logic [btb_pkg::req_count_width-1:0] count;
  logic                                do_pop;

  // Fetch only sends while holding a credit, so a write always finds room
  assign do_pop = q_pop && (count != '0);

  assign q_valid = (count != '0);
  assign q_pc = mem[rd_ptr];

  function automatic logic [btb_pkg::req_ptr_width-1:0] ptr_next(
    input logic [btb_pkg::req_ptr_width-1:0] ptr
  );
    if (ptr == btb_pkg::req_ptr_width'(btb_pkg::req_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Entry storage
  always_ff @(posedge clk) begin
    if (req_valid) begin
      mem[wr_ptr] <= req_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({req_valid, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One credit back to fetch per popped entry, in the cycle after the pop
  always_ff @(posedge clk) begin
    if (reset) begin
      req_credit <= 1'b0;
    end else begin
      req_credit <= do_pop;
    end
  end

endmodule

// ==== common/btb_pkg.sv ====
package btb_pkg;

  // PC and target width
  localparam int addr_width = 32;

  // Branch target table
  localparam int btb_entries = 8;
  localparam int btb_index_width = 3;

  // Fetch request queue, also the fetch side's starting credits
  localparam int req_depth = 4;
  localparam int req_ptr_width = $clog2(req_depth);
  localparam int req_count_width = $clog2(req_depth + 1);

  // Credits held by the prediction output after reset
  localparam int pred_credits = 2;
  localparam int pred_credit_width = $clog2(pred_credits + 1);

  // Sequential fetch increment used on a table miss
  localparam int inst_step = 4;

endpackage
